/* design/bhp_pkg.sv */
`default_nettype none

package bhp_pkg;

	// queue geometry
	localparam int OBQ_SIZE = 16;
	localparam int TAG_W = $clog2(OBQ_SIZE);

	// global history, newest outcome in the top bit
	localparam int BH_SIZE = 8;

	// pattern history table, indexed by pc xor history
	localparam int PHT_BITS = 8;
	localparam int PHT_SIZE = 1 << PHT_BITS;

	// fetch address, word aligned so the index starts at bit 2
	localparam int PC_W = 32;
	localparam int PC_LSB = 2;

	// two-bit saturating counter, top bit is the direction
	typedef enum logic [1:0] {
		strong_nt = 2'b00,
		weak_nt = 2'b01,
		weak_t = 2'b10,
		strong_t = 2'b11
	} ctr_state_t;

	// one speculative history row of the ordered queue
	typedef struct packed {
		logic [BH_SIZE-1:0] branch_history;
		logic [PHT_BITS-1:0] pht_index;
	} obq_row_t;

	typedef struct packed {
		logic valid;
		logic [PC_W-1:0] pc;
	} fetch_req_t;

	typedef struct packed {
		logic valid;
		logic [TAG_W-1:0] tag;
		logic taken;
	} resolve_req_t;

	typedef struct packed {
		logic valid;
		logic [TAG_W-1:0] tag;
	} retire_req_t;

endpackage

`default_nettype wire

/* design/bhp_lookup.sv */
`timescale 1ns/10ps
`default_nettype none

module bhp_lookup (
	input logic clock,
	input logic reset,
	input bhp_pkg::fetch_req_t fetch,
	input logic flush,
	input logic [bhp_pkg::BH_SIZE-1:0] queue_history,
	input logic queue_history_valid,
	input logic [bhp_pkg::BH_SIZE-1:0] committed_history,
	input logic train_en,
	input logic [bhp_pkg::PHT_BITS-1:0] train_index,
	input logic train_taken,
	output logic write_en,
	output bhp_pkg::obq_row_t bh_row,
	output logic pred_valid,
	output logic pred_taken
);

	// counter table
	bhp_pkg::ctr_state_t pht [bhp_pkg::PHT_SIZE];

	// stage register
	logic valid_q;
	logic taken_q;
	bhp_pkg::obq_row_t row_q;

	// lookup path
	logic [bhp_pkg::BH_SIZE-1:0] fetch_history;
	logic [bhp_pkg::PHT_BITS-1:0] fetch_index;
	bhp_pkg::ctr_state_t fetch_ctr;
	logic fetch_taken;
	logic [bhp_pkg::BH_SIZE-1:0] new_history;

	// training path
	bhp_pkg::ctr_state_t train_ctr;
	bhp_pkg::ctr_state_t train_ctr_next;

	// youngest speculative history first:
	// the row still in the stage register has not reached the queue yet
	always_comb begin
		if (valid_q) begin
			fetch_history = row_q.branch_history;
		end else if (queue_history_valid) begin
			fetch_history = queue_history;
		end else begin
			fetch_history = committed_history;
		end
	end

	// gshare hash, history and index are the same width here
	assign fetch_index = fetch.pc[bhp_pkg::PC_LSB +: bhp_pkg::PHT_BITS] ^ fetch_history;
	assign fetch_ctr = pht[fetch_index];
	assign fetch_taken = fetch_ctr[1];

	// predicted bit enters as the newest bit, older bits move toward bit 0
	assign new_history = {fetch_taken, fetch_history[bhp_pkg::BH_SIZE-1:1]};

	// a fetch seen with flush high is on the wrong path as well
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= fetch.valid & ~flush;
		end
	end

	always_ff @(posedge clock) begin
		if (fetch.valid) begin
			taken_q <= fetch_taken;
			row_q.branch_history <= new_history;
			row_q.pht_index <= fetch_index;
		end
	end

	assign pred_valid = valid_q;
	assign pred_taken = taken_q;

	// squashed prediction never reaches the queue
	assign write_en = valid_q & ~flush;
	assign bh_row = row_q;

	// saturating update
	assign train_ctr = pht[train_index];

	always_comb begin
		train_ctr_next = train_ctr;
		case (train_ctr)
			bhp_pkg::strong_nt: begin
				if (train_taken) begin
					train_ctr_next = bhp_pkg::weak_nt;
				end
			end
			bhp_pkg::weak_nt: begin
				train_ctr_next = train_taken ? bhp_pkg::weak_t : bhp_pkg::strong_nt;
			end
			bhp_pkg::weak_t: begin
				train_ctr_next = train_taken ? bhp_pkg::strong_t : bhp_pkg::weak_nt;
			end
			default: begin
				if (!train_taken) begin
					train_ctr_next = bhp_pkg::weak_t;
				end
			end
		endcase
	end

	// all counters start weakly not taken
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < bhp_pkg::PHT_SIZE; i++) begin
				pht[i] <= bhp_pkg::weak_nt;
			end
		end else if (train_en) begin
			pht[train_index] <= train_ctr_next;
		end
	end

endmodule

`default_nettype wire

/* design/bhp_obq.sv */
`timescale 1ns/10ps
`default_nettype none

module bhp_obq (
	input logic clock,
	input logic reset,
	input logic write_en,
	input bhp_pkg::obq_row_t bh_row,
	input logic clear_en,
	input logic [bhp_pkg::TAG_W-1:0] clear_index,
	input logic shift_en,
	input logic [bhp_pkg::TAG_W-1:0] shift_index,
	input logic [bhp_pkg::TAG_W-1:0] rd_tag,
	output logic [bhp_pkg::TAG_W-1:0] row_tag,
	output logic bh_pred_valid,
	output bhp_pkg::obq_row_t bh_pred,
	output bhp_pkg::obq_row_t rd_row
);

	// circular storage, live rows are head up to tail minus one
	bhp_pkg::obq_row_t [bhp_pkg::OBQ_SIZE-1:0] rows;
	bhp_pkg::obq_row_t [bhp_pkg::OBQ_SIZE-1:0] rows_next;

	logic [bhp_pkg::TAG_W-1:0] head;
	logic [bhp_pkg::TAG_W-1:0] head_next;
	logic [bhp_pkg::TAG_W-1:0] tail;
	logic [bhp_pkg::TAG_W-1:0] tail_next;

	logic [bhp_pkg::TAG_W-1:0] newest_tag;
	logic [bhp_pkg::TAG_W-1:0] clear_tag;

	// distance from head, wrapping at the queue size
	function automatic logic is_live(
		input logic [bhp_pkg::TAG_W-1:0] idx,
		input logic [bhp_pkg::TAG_W-1:0] hd,
		input logic [bhp_pkg::TAG_W-1:0] tl
	);
		logic [bhp_pkg::TAG_W-1:0] idx_off;
		logic [bhp_pkg::TAG_W-1:0] tl_off;
		idx_off = idx - hd;
		tl_off = tl - hd;
		return idx_off < tl_off;
	endfunction

	// next row lands at tail
	assign row_tag = tail;

	// head equal to tail means empty
	assign bh_pred_valid = (head != tail);
	assign newest_tag = tail - 1'b1;
	assign bh_pred = rows[newest_tag];

	// resolve and retire share this port
	assign rd_row = rows[rd_tag];

	// clear_index points one past the resolved row
	assign clear_tag = clear_index - 1'b1;

	always_comb begin
		rows_next = rows;
		head_next = head;
		tail_next = tail;

		// retirement first, drops the row and all older ones
		if (shift_en && is_live(shift_index, head, tail)) begin
			head_next = shift_index + 1'b1;
		end

		// then a mispredict, checked against the range left after the shift
		if (clear_en && is_live(clear_tag, head_next, tail)) begin
			tail_next = clear_index;
			// resolved row now carries the real outcome
			rows_next[clear_tag].branch_history[bhp_pkg::BH_SIZE-1] =
				~rows[clear_tag].branch_history[bhp_pkg::BH_SIZE-1];
		end

		// append last
		if (write_en) begin
			rows_next[tail_next] = bh_row;
			tail_next = tail_next + 1'b1;
			// full, oldest row is lost
			if (tail_next == head_next) begin
				head_next = head_next + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
		end else begin
			head <= head_next;
			tail <= tail_next;
		end
	end

	// rows start with all-not-taken history
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < bhp_pkg::OBQ_SIZE; i++) begin
				rows[i] <= '0;
			end
		end else begin
			rows <= rows_next;
		end
	end

endmodule

`default_nettype wire

/* design/bhp_resolve.sv */
`timescale 1ns/10ps
`default_nettype none

module bhp_resolve (
	input logic clock,
	input logic reset,
	input bhp_pkg::resolve_req_t resolve,
	input bhp_pkg::retire_req_t retire,
	input bhp_pkg::obq_row_t rd_row,
	output logic [bhp_pkg::TAG_W-1:0] rd_tag,
	output logic clear_en,
	output logic [bhp_pkg::TAG_W-1:0] clear_index,
	output logic flush,
	output logic shift_en,
	output logic [bhp_pkg::TAG_W-1:0] shift_index,
	output logic train_en,
	output logic [bhp_pkg::PHT_BITS-1:0] train_index,
	output logic train_taken,
	output logic [bhp_pkg::BH_SIZE-1:0] committed_history
);

	logic stored_taken;
	logic mispredict;

	// resolution wins the read port
	// resolve and retire are not expected together
	assign rd_tag = resolve.valid ? resolve.tag : retire.tag;

	// predicted bit is the newest bit of the stored row
	assign stored_taken = rd_row.branch_history[bhp_pkg::BH_SIZE-1];
	// strobes stay low while reset is held
	assign mispredict = resolve.valid & ~reset & (stored_taken != resolve.taken);

	// drop younger rows and the prediction in flight
	assign clear_en = mispredict;
	assign clear_index = resolve.tag + 1'b1;
	assign flush = mispredict;

	// retirement frees the row and everything older
	assign shift_en = retire.valid & ~reset;
	assign shift_index = retire.tag;

	// training request, one cycle late
	always_ff @(posedge clock) begin
		if (reset) begin
			train_en <= 1'b0;
		end else begin
			train_en <= resolve.valid;
		end
	end

	always_ff @(posedge clock) begin
		if (resolve.valid) begin
			train_index <= rd_row.pht_index;
			train_taken <= resolve.taken;
		end
	end

	// committed history follows the retired row
	// which already holds the corrected bit after a mispredict
	always_ff @(posedge clock) begin
		if (reset) begin
			committed_history <= '0;
		end else if (retire.valid) begin
			committed_history <= rd_row.branch_history;
		end
	end

endmodule

`default_nettype wire

/* design/bhp_top.sv */
`timescale 1ns/10ps
`default_nettype none

module bhp_top (
	input logic clock,
	input logic reset,
	input bhp_pkg::fetch_req_t fetch,
	input bhp_pkg::resolve_req_t resolve,
	input bhp_pkg::retire_req_t retire,
	output logic pred_valid,
	output logic pred_taken,
	output logic [bhp_pkg::TAG_W-1:0] pred_tag
);

	// lookup to queue
	logic write_en;
	bhp_pkg::obq_row_t bh_row;
	logic [bhp_pkg::TAG_W-1:0] row_tag;

	// queue to lookup
	logic bh_pred_valid;
	bhp_pkg::obq_row_t bh_pred;

	// resolve to queue
	logic [bhp_pkg::TAG_W-1:0] rd_tag;
	bhp_pkg::obq_row_t rd_row;
	logic clear_en;
	logic [bhp_pkg::TAG_W-1:0] clear_index;
	logic shift_en;
	logic [bhp_pkg::TAG_W-1:0] shift_index;

	// resolve to lookup
	logic flush;
	logic train_en;
	logic [bhp_pkg::PHT_BITS-1:0] train_index;
	logic train_taken;
	logic [bhp_pkg::BH_SIZE-1:0] committed_history;

	bhp_lookup lookup_inst (
		.clock(clock),
		.reset(reset),
		.fetch(fetch),
		.flush(flush),
		.queue_history(bh_pred.branch_history),
		.queue_history_valid(bh_pred_valid),
		.committed_history(committed_history),
		.train_en(train_en),
		.train_index(train_index),
		.train_taken(train_taken),
		.write_en(write_en),
		.bh_row(bh_row),
		.pred_valid(pred_valid),
		.pred_taken(pred_taken)
	);

	bhp_obq obq_inst (
		.clock(clock),
		.reset(reset),
		.write_en(write_en),
		.bh_row(bh_row),
		.clear_en(clear_en),
		.clear_index(clear_index),
		.shift_en(shift_en),
		.shift_index(shift_index),
		.rd_tag(rd_tag),
		.row_tag(row_tag),
		.bh_pred_valid(bh_pred_valid),
		.bh_pred(bh_pred),
		.rd_row(rd_row)
	);

	bhp_resolve resolve_inst (
		.clock(clock),
		.reset(reset),
		.resolve(resolve),
		.retire(retire),
		.rd_row(rd_row),
		.rd_tag(rd_tag),
		.clear_en(clear_en),
		.clear_index(clear_index),
		.flush(flush),
		.shift_en(shift_en),
		.shift_index(shift_index),
		.train_en(train_en),
		.train_index(train_index),
		.train_taken(train_taken),
		.committed_history(committed_history)
	);

	// tag shown is where the pending row will be written
	assign pred_tag = row_tag;

endmodule

`default_nettype wire

/* verif/bhp_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module bhp_asserts (
	input logic clock,
	input logic reset,
	input logic clear_en,
	input logic shift_en,
	input logic write_en,
	input logic flush,
	input logic bh_pred_valid
);

	int failures;

	// queue pointers stay put while in reset
	no_strobe_in_reset: assert property (@(posedge clock) reset |-> !clear_en && !shift_en)
		else begin
			failures++;
			$error("clear or shift strobe seen during reset");
		end

	// a squashed prediction never lands in the queue
	no_write_after_flush: assert property (
		@(posedge clock) disable iff (reset) $past(flush) |-> !write_en
	) else begin
		failures++;
		$error("queue write right after a flush");
	end

	// queue leaves reset empty
	empty_after_reset: assert property (@(posedge clock) $fell(reset) |-> !bh_pred_valid)
		else begin
			failures++;
			$error("queue not empty after reset");
		end

endmodule

`default_nettype wire

/* verif/bhp_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module bhp_checker (
	input logic clock,
	input logic reset,
	input bhp_pkg::fetch_req_t fetch,
	input bhp_pkg::resolve_req_t resolve,
	input bhp_pkg::retire_req_t retire,
	input logic pred_valid,
	input logic pred_taken,
	input logic [bhp_pkg::TAG_W-1:0] pred_tag
);

	int checks;
	int errors;

	// model of counters, queue rows and pointers
	logic [1:0] ctr [bhp_pkg::PHT_SIZE];
	logic [bhp_pkg::BH_SIZE-1:0] hist [bhp_pkg::OBQ_SIZE];
	logic [bhp_pkg::PHT_BITS-1:0] idx [bhp_pkg::OBQ_SIZE];
	logic resolved [bhp_pkg::OBQ_SIZE];
	logic [bhp_pkg::TAG_W-1:0] head;
	logic [bhp_pkg::TAG_W-1:0] tail;
	logic [bhp_pkg::BH_SIZE-1:0] committed;

	// prediction held in stage one
	logic pend_valid;
	logic pend_taken;
	logic [bhp_pkg::BH_SIZE-1:0] pend_hist;
	logic [bhp_pkg::PHT_BITS-1:0] pend_idx;

	// training lands one edge after the resolution
	logic tr_en;
	logic tr_taken;
	logic [bhp_pkg::PHT_BITS-1:0] tr_idx;

	// live rows run from head up to tail, modulo the queue size
	function automatic logic in_range(input int tag, input int hd, input int tl);
		int n;
		n = bhp_pkg::OBQ_SIZE;
		return ((tag - hd + n) % n) < ((tl - hd + n) % n);
	endfunction

	function automatic logic [1:0] step(input logic [1:0] c, input logic taken);
		if (taken) begin
			return (c == 2'b11) ? c : c + 2'b01;
		end
		return (c == 2'b00) ? c : c - 2'b01;
	endfunction

	always @(posedge clock) begin
		logic [bhp_pkg::BH_SIZE-1:0] f_hist;
		logic [bhp_pkg::PHT_BITS-1:0] f_idx;
		logic [bhp_pkg::TAG_W-1:0] newest;
		logic f_taken;
		logic mis;
		if (reset) begin
			for (int i = 0; i < bhp_pkg::PHT_SIZE; i++) begin
				ctr[i] = 2'b01;
			end
			for (int i = 0; i < bhp_pkg::OBQ_SIZE; i++) begin
				hist[i] = '0;
				idx[i] = '0;
				resolved[i] = 1'b0;
			end
			head = '0;
			tail = '0;
			committed = '0;
			pend_valid = 1'b0;
			tr_en = 1'b0;
		end else begin
			// outputs still show the state before this edge
			checks++;
			if (pred_valid !== pend_valid) begin
				errors++;
				$display("error at %0t ns: pred_valid %b, expected %b", $time, pred_valid,
					pend_valid);
			end else if (pend_valid && (pred_taken !== pend_taken || pred_tag !== tail)) begin
				errors++;
				$display("error at %0t ns: tag %0d taken %b, expected tag %0d taken %b",
					$time, pred_tag, pred_taken, tail, pend_taken);
			end
			// youngest history wins, counters read before training
			newest = tail - 1'b1;
			f_hist = pend_valid ? pend_hist : (head != tail ? hist[newest] : committed);
			f_idx = fetch.pc[bhp_pkg::PC_LSB +: bhp_pkg::PHT_BITS] ^ f_hist;
			f_taken = ctr[f_idx][1];
			mis = resolve.valid && (hist[resolve.tag][bhp_pkg::BH_SIZE-1] != resolve.taken);
			if (tr_en) begin
				ctr[tr_idx] = step(ctr[tr_idx], tr_taken);
			end
			tr_en = resolve.valid;
			if (resolve.valid) begin
				tr_idx = idx[resolve.tag];
				tr_taken = resolve.taken;
				resolved[resolve.tag] = 1'b1;
			end
			// shift, then clear, then write
			if (retire.valid) begin
				committed = hist[retire.tag];
				if (in_range(retire.tag, head, tail)) begin
					head = retire.tag + 1'b1;
				end
			end
			if (mis && in_range(resolve.tag, head, tail)) begin
				tail = resolve.tag + 1'b1;
				hist[resolve.tag][bhp_pkg::BH_SIZE-1] = resolve.taken;
			end
			if (pend_valid && !mis) begin
				hist[tail] = pend_hist;
				idx[tail] = pend_idx;
				resolved[tail] = 1'b0;
				tail = tail + 1'b1;
				if (tail == head) begin
					head = head + 1'b1;
				end
			end
			pend_valid = fetch.valid && !mis;
			if (fetch.valid) begin
				pend_taken = f_taken;
				pend_hist = {f_taken, f_hist[bhp_pkg::BH_SIZE-1:1]};
				pend_idx = f_idx;
			end
		end
	end

endmodule

`default_nettype wire

/* verif/bhp_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module bhp_tb;

	localparam int PERIOD = 100;
	localparam int RESET_CYCLES = 16;
	localparam int PHASE_CYCLES = 40 + 120 + 80 + 120 + 50 + 2000;
	// two idle cycles after each of the six phases, plus the tail
	localparam int MARGIN = 200;
	localparam int RUN_CYCLES = RESET_CYCLES + PHASE_CYCLES + 12 + MARGIN;

	logic clock;
	logic reset;
	bhp_pkg::fetch_req_t fetch;
	bhp_pkg::resolve_req_t resolve;
	bhp_pkg::retire_req_t retire;
	logic pred_valid;
	logic pred_taken;
	logic [bhp_pkg::TAG_W-1:0] pred_tag;

	int seed;
	int tests;
	int tests_failed;
	int last_checks;
	int last_errors;
	logic [31:0] rnd;

	bhp_top bhp_top_inst (
		.clock(clock),
		.reset(reset),
		.fetch(fetch),
		.resolve(resolve),
		.retire(retire),
		.pred_valid(pred_valid),
		.pred_taken(pred_taken),
		.pred_tag(pred_tag)
	);

	bhp_checker checker_inst (
		.clock(clock),
		.reset(reset),
		.fetch(fetch),
		.resolve(resolve),
		.retire(retire),
		.pred_valid(pred_valid),
		.pred_taken(pred_taken),
		.pred_tag(pred_tag)
	);

	bind bhp_top bhp_asserts bhp_asserts_inst (
		.clock(clock),
		.reset(reset),
		.clear_en(clear_en),
		.shift_en(shift_en),
		.write_en(write_en),
		.flush(flush),
		.bh_pred_valid(bh_pred_valid)
	);

	always #(PERIOD / 2) clock = ~clock;

	function automatic int pick(input int range);
		return $unsigned($random(seed)) % range;
	endfunction

	// res_mode 0 resolves as predicted, 1 against it, 2 at random
	task automatic run_phase(input string name, input int cycles, input int fetch_pct,
		input int res_pct, input int res_mode, input int ret_pct, input logic [31:0] pc_mask);
		int count;
		int tag;
		logic stored;
		for (int c = 0; c < cycles; c++) begin
			@(negedge clock);
			fetch.valid = pick(100) < fetch_pct;
			fetch.pc = $random(seed) & pc_mask;
			resolve = '0;
			retire = '0;
			count = (int'(checker_inst.tail) - int'(checker_inst.head) + bhp_pkg::OBQ_SIZE)
				% bhp_pkg::OBQ_SIZE;
			// only live rows not yet resolved
			if (count > 0 && pick(100) < res_pct) begin
				tag = (int'(checker_inst.head) + pick(count)) % bhp_pkg::OBQ_SIZE;
				if (!checker_inst.resolved[tag]) begin
					stored = checker_inst.hist[tag][bhp_pkg::BH_SIZE-1];
					resolve.valid = 1'b1;
					resolve.tag = tag[bhp_pkg::TAG_W-1:0];
					resolve.taken = (res_mode == 0) ? stored :
						(res_mode == 1) ? ~stored : (pick(2) == 1);
				end
			end
			// in order, oldest row once resolved
			if (!resolve.valid && count > 0 && checker_inst.resolved[checker_inst.head]
				&& pick(100) < ret_pct) begin
				retire.valid = 1'b1;
				retire.tag = checker_inst.head;
			end
		end
		@(negedge clock);
		fetch = '0;
		resolve = '0;
		retire = '0;
		// the last prediction of the phase is compared on the next edge
		@(negedge clock);
		tests++;
		if (checker_inst.errors != last_errors) begin
			tests_failed++;
		end
		$display("test %0d %s: %0d checks, %0d errors", tests, name,
			checker_inst.checks - last_checks, checker_inst.errors - last_errors);
		last_checks = checker_inst.checks;
		last_errors = checker_inst.errors;
	endtask

	initial begin
		seed = 32'hb7e9_62d9;
		clock = 1'b0;
		reset = 1'b1;
		fetch = '0;
		resolve = '0;
		retire = '0;
		tests = 0;
		tests_failed = 0;
		last_checks = 0;
		last_errors = 0;
		// strobes toggle while reset is held and must have no effect
		for (int c = 0; c < RESET_CYCLES - 1; c++) begin
			@(negedge clock);
			rnd = $random(seed);
			fetch.valid = rnd[0];
			fetch.pc = $random(seed);
			resolve.valid = rnd[1];
			resolve.tag = rnd[2 +: bhp_pkg::TAG_W];
			resolve.taken = rnd[8];
			retire.valid = rnd[9];
			retire.tag = rnd[10 +: bhp_pkg::TAG_W];
		end
		@(negedge clock);
		reset = 1'b0;
		fetch = '0;
		resolve = '0;
		retire = '0;
		run_phase("fetch stream after reset", 40, 100, 0, 0, 0, 32'hffff_fffc);
		run_phase("training on matching outcomes", 120, 60, 70, 0, 0, 32'h0000_003c);
		run_phase("mispredict squash", 80, 80, 30, 1, 0, 32'h0000_00fc);
		run_phase("in-order retirement", 120, 20, 60, 2, 80, 32'h0000_003c);
		run_phase("queue overwrite when full", 50, 100, 0, 0, 0, 32'hffff_fffc);
		run_phase("random mix", 2000, 60, 40, 2, 40, 32'h0000_03fc);
		$display("total: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
			tests, tests_failed, checker_inst.checks, checker_inst.errors,
			bhp_top_inst.bhp_asserts_inst.failures);
		if (tests_failed == 0 && checker_inst.errors == 0
			&& bhp_top_inst.bhp_asserts_inst.failures == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// budget covers reset, every phase and a margin
	initial begin
		#(RUN_CYCLES * PERIOD);
		$display("timeout: run did not finish within %0d cycles", RUN_CYCLES);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* bhp.f */
design/bhp_pkg.sv
design/bhp_lookup.sv
design/bhp_obq.sv
design/bhp_resolve.sv
design/bhp_top.sv
verif/bhp_asserts.sv
verif/bhp_checker.sv
verif/bhp_tb.sv
